// ==== design/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

   ////////////////////////////////////////
   // Widths
   ////////////////////////////////////////
   localparam int DATA_W     = 32;
   localparam int REG_ADDR_W = 5;
   localparam int ALU_OP_W   = 4;

   localparam logic [REG_ADDR_W-1:0] REG_RA = 5'd31;  // Link register

   ////////////////////////////////////////
   // ALU operation codes
   ////////////////////////////////////////
   localparam logic [ALU_OP_W-1:0] ALU_AND    = 4'b0000;
   localparam logic [ALU_OP_W-1:0] ALU_OR     = 4'b0001;
   localparam logic [ALU_OP_W-1:0] ALU_ADD    = 4'b0010;
   localparam logic [ALU_OP_W-1:0] ALU_SUB    = 4'b0110;
   localparam logic [ALU_OP_W-1:0] ALU_SLT    = 4'b0111;
   localparam logic [ALU_OP_W-1:0] ALU_LUI    = 4'b1000;
   localparam logic [ALU_OP_W-1:0] ALU_XOR    = 4'b1001;
   localparam logic [ALU_OP_W-1:0] ALU_NOR    = 4'b1010;
   localparam logic [ALU_OP_W-1:0] ALU_SLL    = 4'b1011;
   localparam logic [ALU_OP_W-1:0] ALU_SRL    = 4'b1100;
   localparam logic [ALU_OP_W-1:0] ALU_SRA    = 4'b1101;
   localparam logic [ALU_OP_W-1:0] ALU_PASS_A = 4'b1110;  // Jumps

   ////////////////////////////////////////
   // Opcodes and R-type funct fields
   ////////////////////////////////////////
   localparam logic [5:0] OP_RTYPE = 6'h00, OP_J     = 6'h02, OP_JAL  = 6'h03;
   localparam logic [5:0] OP_ADDI  = 6'h08, OP_ADDIU = 6'h09, OP_SLTI = 6'h0a;
   localparam logic [5:0] OP_ANDI  = 6'h0c, OP_ORI   = 6'h0d, OP_XORI = 6'h0e;
   localparam logic [5:0] OP_LUI   = 6'h0f, OP_LW    = 6'h23, OP_SW   = 6'h2b;

   localparam logic [5:0] FN_SLL  = 6'h00, FN_SRL  = 6'h02, FN_SRA  = 6'h03;
   localparam logic [5:0] FN_SLLV = 6'h04, FN_SRLV = 6'h06, FN_SRAV = 6'h07;
   localparam logic [5:0] FN_JR   = 6'h08, FN_JALR = 6'h09;
   localparam logic [5:0] FN_ADD  = 6'h20, FN_ADDU = 6'h21, FN_SUB  = 6'h22;
   localparam logic [5:0] FN_SUBU = 6'h23, FN_AND  = 6'h24, FN_OR   = 6'h25;
   localparam logic [5:0] FN_XOR  = 6'h26, FN_NOR  = 6'h27, FN_SLT  = 6'h2a;

   ////////////////////////////////////////
   // Pipeline bundles
   ////////////////////////////////////////
   typedef enum logic [1:0] {FWD_NONE = 2'd0, FWD_EX_MEM = 2'd1, FWD_WB = 2'd2} fwd_src_t;

   typedef struct packed {
      logic                  valid;
      logic [5:0]            opcode;
      logic [5:0]            funct;
      logic [4:0]            shamt;
      logic [REG_ADDR_W-1:0] rs;
      logic [REG_ADDR_W-1:0] rt;
      logic [REG_ADDR_W-1:0] rd;
      logic [DATA_W-1:0]     rs_data;
      logic [DATA_W-1:0]     rt_data;
      logic [15:0]           imm16;
   } id_ex_t;

   typedef struct packed {
      logic [ALU_OP_W-1:0] alu_op;
      logic                b_is_imm;
      logic                zero_ext;
      logic                a_is_shamt;      // Fixed shift, rt shifted by shamt
      logic                a_is_var_shift;  // Variable shift, rt shifted by rs
      logic                dest_is_rt;
      logic                reg_write;
      logic                mem_read;
      logic                mem_write;
      fwd_src_t            fwd_a;
      fwd_src_t            fwd_b;
   } ex_ctrl_t;

   typedef struct packed {
      logic                  reg_write;
      logic [REG_ADDR_W-1:0] dest;
      logic [DATA_W-1:0]     data;
   } wb_fwd_t;

   typedef struct packed {
      logic                  valid;
      logic                  reg_write;
      logic                  mem_read;
      logic                  mem_write;
      logic [REG_ADDR_W-1:0] dest;
      logic [DATA_W-1:0]     alu_result;
      logic [DATA_W-1:0]     store_data;
   } ex_mem_t;

endpackage

`default_nettype wire

// ==== design/ex_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_control (
   input  wire mips_pkg::id_ex_t  i_id_ex,
   input  wire mips_pkg::ex_mem_t i_ex_mem,
   input  wire mips_pkg::wb_fwd_t i_wb_fwd,
   output mips_pkg::ex_ctrl_t     o_ctrl
);
   import mips_pkg::*;

   ex_ctrl_t dec;  // Raw decode, before the valid gate

   // EX/MEM wins over WB, register 0 is hardwired
   function automatic fwd_src_t fwd_select(
      input logic [REG_ADDR_W-1:0] src,
      input ex_mem_t               exm,
      input wb_fwd_t               wb
   );
      fwd_src_t sel;
      sel = FWD_NONE;
      if (src != '0)
      begin
         if (exm.valid && exm.reg_write && (exm.dest == src))
            sel = FWD_EX_MEM;
         else if (wb.reg_write && (wb.dest == src))
            sel = FWD_WB;
      end
      return sel;
   endfunction

   ////////////////////////////////////////
   // Opcode and funct decode
   ////////////////////////////////////////
   always_comb
   begin
      dec        = '0;
      dec.alu_op = ALU_ADD;
      case (i_id_ex.opcode)
         OP_RTYPE:
         begin
            dec.reg_write = 1'b1;                             // Most R-type write rd
            case (i_id_ex.funct)
               FN_SLL:  begin dec.alu_op = ALU_SLL; dec.a_is_shamt = 1'b1; end
               FN_SRL:  begin dec.alu_op = ALU_SRL; dec.a_is_shamt = 1'b1; end
               FN_SRA:  begin dec.alu_op = ALU_SRA; dec.a_is_shamt = 1'b1; end
               FN_SLLV: begin dec.alu_op = ALU_SLL; dec.a_is_var_shift = 1'b1; end
               FN_SRLV: begin dec.alu_op = ALU_SRL; dec.a_is_var_shift = 1'b1; end
               FN_SRAV: begin dec.alu_op = ALU_SRA; dec.a_is_var_shift = 1'b1; end
               FN_ADD, FN_ADDU: dec.alu_op = ALU_ADD;        // No overflow trap
               FN_SUB, FN_SUBU: dec.alu_op = ALU_SUB;
               FN_AND:  dec.alu_op = ALU_AND;
               FN_OR:   dec.alu_op = ALU_OR;
               FN_XOR:  dec.alu_op = ALU_XOR;
               FN_NOR:  dec.alu_op = ALU_NOR;
               FN_SLT:  dec.alu_op = ALU_SLT;
               FN_JALR: dec.alu_op = ALU_PASS_A;             // Link to r31
               FN_JR:
               begin
                  dec.alu_op    = ALU_PASS_A;
                  dec.reg_write = 1'b0;
               end
               default: dec.reg_write = 1'b0;                // Unsupported funct
            endcase
         end
         OP_ADDI, OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI:
         begin
            dec.b_is_imm   = 1'b1;
            dec.dest_is_rt = 1'b1;
            dec.reg_write  = 1'b1;
            case (i_id_ex.opcode)
               OP_SLTI: dec.alu_op = ALU_SLT;
               OP_ANDI: begin dec.alu_op = ALU_AND; dec.zero_ext = 1'b1; end
               OP_ORI:  begin dec.alu_op = ALU_OR;  dec.zero_ext = 1'b1; end
               OP_XORI: begin dec.alu_op = ALU_XOR; dec.zero_ext = 1'b1; end
               OP_LUI:  dec.alu_op = ALU_LUI;
               default: dec.alu_op = ALU_ADD;               // ADDI, ADDIU
            endcase
         end
         OP_LW:
         begin
            dec.b_is_imm   = 1'b1;                             // Base plus offset
            dec.dest_is_rt = 1'b1;
            dec.reg_write  = 1'b1;
            dec.mem_read   = 1'b1;
         end
         OP_SW:
         begin
            dec.b_is_imm  = 1'b1;
            dec.mem_write = 1'b1;
         end
         OP_J:   dec.alu_op = ALU_PASS_A;
         OP_JAL:
         begin
            dec.alu_op    = ALU_PASS_A;
            dec.reg_write = 1'b1;
         end
         default: dec.alu_op = ALU_ADD;
      endcase
   end

   // Gate side effects with valid and attach forwarding
   always_comb
   begin
      o_ctrl       = dec;
      o_ctrl.fwd_a = fwd_select(i_id_ex.rs, i_ex_mem, i_wb_fwd);
      o_ctrl.fwd_b = fwd_select(i_id_ex.rt, i_ex_mem, i_wb_fwd);
      if (!i_id_ex.valid)
      begin
         o_ctrl.reg_write = 1'b0;
         o_ctrl.mem_read  = 1'b0;
         o_ctrl.mem_write = 1'b0;
      end
   end

   always_comb
   begin
      assert final (!(o_ctrl.mem_read && o_ctrl.mem_write))
         else $error("ex_control: load and store decoded together");
   end

endmodule

`default_nettype wire

// ==== design/operand_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_select (
   input  wire mips_pkg::id_ex_t            i_id_ex,
   input  wire mips_pkg::ex_ctrl_t          i_ctrl,
   input  wire [mips_pkg::DATA_W-1:0]       i_ex_mem_result,
   input  wire [mips_pkg::DATA_W-1:0]       i_wb_data,
   output logic [mips_pkg::DATA_W-1:0]      o_alu_a,
   output logic [mips_pkg::DATA_W-1:0]      o_alu_b,
   output logic [mips_pkg::DATA_W-1:0]      o_store_data
);
   import mips_pkg::*;

   logic [DATA_W-1:0] rs_fwd;   // rs after forwarding
   logic [DATA_W-1:0] rt_fwd;   // rt after forwarding
   logic [DATA_W-1:0] imm_ext;
   logic [DATA_W-1:0] shamt_ext;
   logic              is_shift;

   ////////////////////////////////////////
   // Forwarding muxes
   ////////////////////////////////////////
   always_comb
   begin
      case (i_ctrl.fwd_a)
         FWD_EX_MEM: rs_fwd = i_ex_mem_result;
         FWD_WB:     rs_fwd = i_wb_data;
         default:    rs_fwd = i_id_ex.rs_data;
      endcase
   end

   always_comb
   begin
      case (i_ctrl.fwd_b)
         FWD_EX_MEM: rt_fwd = i_ex_mem_result;
         FWD_WB:     rt_fwd = i_wb_data;
         default:    rt_fwd = i_id_ex.rt_data;
      endcase
   end

   ////////////////////////////////////////
   // Immediate and shift amount
   ////////////////////////////////////////
   always_comb
   begin
      if (i_ctrl.zero_ext)
         imm_ext = {{(DATA_W-16){1'b0}}, i_id_ex.imm16};      // ANDI, ORI, XORI
      else
         imm_ext = {{(DATA_W-16){i_id_ex.imm16[15]}}, i_id_ex.imm16};
   end

   assign shamt_ext = {{(DATA_W-5){1'b0}}, i_id_ex.shamt};
   assign is_shift  = i_ctrl.a_is_shamt | i_ctrl.a_is_var_shift;

   // Shifts move rt into A, amount goes to B
   always_comb
   begin
      o_alu_a = is_shift ? rt_fwd : rs_fwd;
      if (i_ctrl.a_is_shamt)
         o_alu_b = shamt_ext;
      else if (i_ctrl.a_is_var_shift)
         o_alu_b = rs_fwd;                                    // Masked in the ALU
      else if (i_ctrl.b_is_imm)
         o_alu_b = imm_ext;
      else
         o_alu_b = rt_fwd;
   end

   assign o_store_data = rt_fwd;                              // SW data

endmodule

`default_nettype wire

// ==== design/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
   input  wire [mips_pkg::ALU_OP_W-1:0]  i_alu_op,
   input  wire [mips_pkg::DATA_W-1:0]    i_data_a,
   input  wire [mips_pkg::DATA_W-1:0]    i_data_b,
   output logic [mips_pkg::DATA_W-1:0]   o_result
);
   import mips_pkg::*;

   logic [4:0] sh_amt;      // Low five bits of B
   logic       op_known;    // Code is in the operation set

   assign sh_amt = i_data_b[4:0];

   ////////////////////////////////////////
   // Operation select
   ////////////////////////////////////////
   always_comb
   begin
      op_known = 1'b1;
      case (i_alu_op)
         ALU_SLL:
         begin
            o_result = i_data_a << sh_amt;                     // SLL, SLLV
         end
         ALU_SRL:
         begin
            o_result = i_data_a >> sh_amt;                     // SRL, SRLV
         end
         ALU_SRA:
         begin
            o_result = $unsigned($signed(i_data_a) >>> sh_amt);
         end
         ALU_ADD:
         begin
            o_result = i_data_a + i_data_b;                    // Also LW, SW address
         end
         ALU_SUB:
         begin
            o_result = i_data_a - i_data_b;
         end
         ALU_AND:
         begin
            o_result = i_data_a & i_data_b;
         end
         ALU_OR:
         begin
            o_result = i_data_a | i_data_b;
         end
         ALU_XOR:
         begin
            o_result = i_data_a ^ i_data_b;
         end
         ALU_NOR:
         begin
            o_result = ~(i_data_a | i_data_b);
         end
         ALU_SLT:
         begin
            o_result = {{(DATA_W-1){1'b0}}, ($signed(i_data_a) < $signed(i_data_b))};
         end
         ALU_LUI:
         begin
            o_result = i_data_b << 16;                         // Immediate to upper half
         end
         ALU_PASS_A:
         begin
            o_result = i_data_a;                               // Jump target or link
         end
         default:
         begin
            // Unknown codes fall back to add
            o_result = i_data_a + i_data_b;
            op_known = 1'b0;
         end
      endcase
   end

   always_comb
   begin
      assert final (op_known)
         else $error("alu: unknown operation code %h", i_alu_op);
   end

endmodule

`default_nettype wire

// ==== design/ex_mem_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_mem_reg (
   input  wire                           i_clk,
   input  wire                           i_rst,
   input  wire                           i_stall,
   input  wire                           i_flush,
   input  wire mips_pkg::id_ex_t         i_id_ex,
   input  wire mips_pkg::ex_ctrl_t       i_ctrl,
   input  wire [mips_pkg::DATA_W-1:0]    i_result,
   input  wire [mips_pkg::DATA_W-1:0]    i_store_data,
   output mips_pkg::ex_mem_t             o_ex_mem
);
   import mips_pkg::*;

   ex_mem_t               next;
   logic [REG_ADDR_W-1:0] dest_sel;
   logic                  is_link;

   // Only JAL and JALR pass A and write a register
   assign is_link = (i_ctrl.alu_op == ALU_PASS_A) && i_ctrl.reg_write;

   always_comb
   begin
      if (is_link)
         dest_sel = REG_RA;
      else if (i_ctrl.dest_is_rt)
         dest_sel = i_id_ex.rt;
      else
         dest_sel = i_id_ex.rd;
   end

   always_comb
   begin
      next            = '0;
      next.valid      = i_id_ex.valid;
      next.reg_write  = i_ctrl.reg_write;
      next.mem_read   = i_ctrl.mem_read;
      next.mem_write  = i_ctrl.mem_write;
      next.dest       = dest_sel;
      next.alu_result = i_result;
      next.store_data = i_store_data;
   end

   ////////////////////////////////////////
   // Pipeline register
   ////////////////////////////////////////
   always_ff @(posedge i_clk)
   begin
      if (i_rst)
         o_ex_mem <= '0;
      else if (!i_stall)                                      // Stall holds, even over flush
      begin
         if (i_flush)
            o_ex_mem <= '0;                                   // Bubble
         else
            o_ex_mem <= next;
      end
   end

   a_stall_hold: assert property (@(posedge i_clk) disable iff (i_rst)
      i_stall |=> $stable(o_ex_mem))
      else $error("ex_mem_reg: contents changed during stall");

endmodule

`default_nettype wire

// ==== design/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
   input  wire                       i_clk,
   input  wire                       i_rst,
   input  wire                       i_stall,
   input  wire                       i_flush,
   input  wire mips_pkg::id_ex_t     i_id_ex,
   input  wire mips_pkg::wb_fwd_t    i_wb_fwd,
   output mips_pkg::ex_mem_t         o_ex_mem
);
   import mips_pkg::*;

   ex_ctrl_t          ctrl;
   logic [DATA_W-1:0] alu_a;
   logic [DATA_W-1:0] alu_b;
   logic [DATA_W-1:0] alu_result;
   logic [DATA_W-1:0] store_data;

   ////////////////////////////////////////
   // Control
   ////////////////////////////////////////
   ex_control u_ex_control (
      .i_id_ex  (i_id_ex),
      .i_ex_mem (o_ex_mem),             // Own EX/MEM feeds forwarding
      .i_wb_fwd (i_wb_fwd),
      .o_ctrl   (ctrl)
   );

   ////////////////////////////////////////
   // Datapath
   ////////////////////////////////////////
   operand_select u_operand_select (
      .i_id_ex         (i_id_ex),
      .i_ctrl          (ctrl),
      .i_ex_mem_result (o_ex_mem.alu_result),
      .i_wb_data       (i_wb_fwd.data),
      .o_alu_a         (alu_a),
      .o_alu_b         (alu_b),
      .o_store_data    (store_data)
   );

   alu u_alu (
      .i_alu_op (ctrl.alu_op),
      .i_data_a (alu_a),
      .i_data_b (alu_b),
      .o_result (alu_result)
   );

   ex_mem_reg u_ex_mem_reg (
      .i_clk        (i_clk),
      .i_rst        (i_rst),
      .i_stall      (i_stall),
      .i_flush      (i_flush),
      .i_id_ex      (i_id_ex),
      .i_ctrl       (ctrl),
      .i_result     (alu_result),
      .i_store_data (store_data),
      .o_ex_mem     (o_ex_mem)
   );

endmodule

`default_nettype wire

// ==== sim/ex_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_checker (
   input  wire                    i_clk,
   input  wire                    i_rst,
   input  wire                    i_check,     // Entry applied this cycle
   input  wire [31:0]             i_index,
   input  wire                    i_lcg,
   input  wire mips_pkg::ex_mem_t i_expected,
   input  wire mips_pkg::ex_mem_t i_actual,
   output int                     o_checked,
   output int                     o_failed
);
   import mips_pkg::*;

   logic        pend;
   logic [31:0] idx_q;
   logic        lcg_q;
   ex_mem_t     exp_q;

   initial
   begin
      o_checked = 0;
      o_failed  = 0;
   end

   // Latch the entry that the DUT captures at this edge
   always @(posedge i_clk)
   begin
      pend  <= i_check && !i_rst;
      idx_q <= i_index;
      lcg_q <= i_lcg;
      exp_q <= i_expected;
   end

   task automatic field_check(input string name, input logic [31:0] exp_v,
                              input logic [31:0] act_v, inout bit bad);
      if (exp_v !== act_v)
      begin
         $display("ERROR test %0d %s expected %h actual %h", idx_q, name, exp_v, act_v);
         bad = 1'b1;
      end
   endtask

   ////////////////////////////////////////
   // Compare at the falling edge, outputs settled
   ////////////////////////////////////////
   always @(negedge i_clk)
   begin
      bit bad;
      bad = 1'b0;
      if (pend)
      begin
         field_check("valid", 32'(exp_q.valid), 32'(i_actual.valid), bad);
         field_check("reg_write", 32'(exp_q.reg_write), 32'(i_actual.reg_write), bad);
         field_check("mem_read", 32'(exp_q.mem_read), 32'(i_actual.mem_read), bad);
         field_check("mem_write", 32'(exp_q.mem_write), 32'(i_actual.mem_write), bad);
         field_check("dest", 32'(exp_q.dest), 32'(i_actual.dest), bad);
         field_check("alu_result", exp_q.alu_result, i_actual.alu_result, bad);
         field_check("store_data", exp_q.store_data, i_actual.store_data, bad);
         $display("test %0d (%s) %s", idx_q, lcg_q ? "lcg" : "fixed", bad ? "failed" : "ok");
         o_checked = o_checked + 1;
         if (bad)
            o_failed = o_failed + 1;
      end
   end

endmodule

`default_nettype wire

// ==== sim/tb_execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_execute_stage;
   import mips_pkg::*;

   typedef struct packed {
      id_ex_t  id;
      wb_fwd_t wb;
      logic    stall;
      logic    flush;
      logic    is_lcg;     // Operands drawn from the LCG
      ex_mem_t exp;
   } entry_t;

   logic        clk;
   logic        rst;
   logic        stall;
   logic        flush;
   id_ex_t      id_ex;
   wb_fwd_t     wb_fwd;
   ex_mem_t     ex_mem;
   logic        check;
   logic [31:0] index;
   logic        cur_lcg;
   ex_mem_t     cur_exp;
   int          checked;
   int          failed;
   int          cycles;
   entry_t      table_q[$];
   ex_mem_t     last_exp;
   logic [31:0] lcg_state;

   execute_stage u_execute_stage (
      .i_clk    (clk),
      .i_rst    (rst),
      .i_stall  (stall),
      .i_flush  (flush),
      .i_id_ex  (id_ex),
      .i_wb_fwd (wb_fwd),
      .o_ex_mem (ex_mem)
   );

   ex_checker u_ex_checker (
      .i_clk      (clk),
      .i_rst      (rst),
      .i_check    (check),
      .i_index    (index),
      .i_lcg      (cur_lcg),
      .i_expected (cur_exp),
      .i_actual   (ex_mem),
      .o_checked  (checked),
      .o_failed   (failed)
   );

   always #20 clk = ~clk;

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   ////////////////////////////////////////
   // Reference model of the MIPS operations
   ////////////////////////////////////////
   function automatic logic [31:0] ref_result(input logic [5:0] opc, input logic [5:0] fn,
                                              input logic [4:0] sh, input logic [31:0] a,
                                              input logic [31:0] b, input logic [15:0] imm);
      logic [31:0] sx;
      logic [31:0] zx;
      logic [31:0] r;
      sx = {{16{imm[15]}}, imm};
      zx = {16'h0, imm};
      r  = '0;
      case (opc)
         OP_RTYPE:
         begin
            case (fn)
               FN_SLL:          r = b << sh;
               FN_SRL:          r = b >> sh;
               FN_SRA:          r = $unsigned($signed(b) >>> sh);
               FN_SLLV:         r = b << a[4:0];
               FN_SRLV:         r = b >> a[4:0];
               FN_SRAV:         r = $unsigned($signed(b) >>> a[4:0]);
               FN_ADD, FN_ADDU: r = a + b;
               FN_SUB, FN_SUBU: r = a - b;
               FN_AND:          r = a & b;
               FN_OR:           r = a | b;
               FN_XOR:          r = a ^ b;
               FN_NOR:          r = ~(a | b);
               FN_SLT:          r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
               default:         r = '0;
            endcase
         end
         OP_ADDI, OP_ADDIU: r = a + sx;
         OP_SLTI:           r = ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
         OP_ANDI:           r = a & zx;
         OP_ORI:            r = a | zx;
         OP_XORI:           r = a ^ zx;
         OP_LUI:            r = {imm, 16'h0};
         default:           r = '0;
      endcase
      return r;
   endfunction

   function automatic id_ex_t r_id(input logic [5:0] fn, input logic [4:0] rs,
                                   input logic [4:0] rt, input logic [4:0] rd,
                                   input logic [4:0] sh, input logic [31:0] rs_d,
                                   input logic [31:0] rt_d);
      return '{valid: 1'b1, opcode: OP_RTYPE, funct: fn, shamt: sh, rs: rs, rt: rt,
               rd: rd, rs_data: rs_d, rt_data: rt_d, imm16: 16'h0};
   endfunction

   function automatic id_ex_t i_id(input logic [5:0] opc, input logic [4:0] rs,
                                   input logic [4:0] rt, input logic [15:0] imm,
                                   input logic [31:0] rs_d, input logic [31:0] rt_d);
      return '{valid: 1'b1, opcode: opc, funct: 6'h0, shamt: 5'h0, rs: rs, rt: rt,
               rd: 5'h0, rs_data: rs_d, rt_data: rt_d, imm16: imm};
   endfunction

   function automatic ex_mem_t exm(input logic rw, input logic mr, input logic mw,
                                   input logic [4:0] dest, input logic [31:0] res,
                                   input logic [31:0] sd);
      return '{valid: 1'b1, reg_write: rw, mem_read: mr, mem_write: mw, dest: dest,
               alu_result: res, store_data: sd};
   endfunction

   function automatic wb_fwd_t wbf(input logic rw, input logic [4:0] dest,
                                   input logic [31:0] data);
      return '{reg_write: rw, dest: dest, data: data};
   endfunction

   // Stall keeps the last value and flush empties the register
   task automatic add(input id_ex_t id, input wb_fwd_t wb, input logic st,
                      input logic fl, input logic lcg, input ex_mem_t exp);
      ex_mem_t e;
      if (st)
         e = last_exp;
      else if (fl)
         e = '0;
      else
         e = exp;
      last_exp = e;
      table_q.push_back('{id: id, wb: wb, stall: st, flush: fl, is_lcg: lcg, exp: e});
   endtask

   ////////////////////////////////////////
   // Stimulus table
   ////////////////////////////////////////
   task automatic build_table();
      logic [5:0]  fns [0:14];
      logic [5:0]  ops [0:6];
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] r;
      wb_fwd_t     no_wb;
      fns = '{FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV, FN_ADD, FN_ADDU,
              FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT};
      ops = '{OP_ADDI, OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
      no_wb    = '0;
      last_exp = '0;                                       // Reset value
      add('0, no_wb, 1'b1, 1'b0, 1'b0, '0);
      add(r_id(FN_ADDU, 1, 2, 3, 0, 5, 7), no_wb, 0, 0, 0, exm(1, 0, 0, 3, 32'hC, 7));
      add(r_id(FN_SUB, 3, 4, 5, 0, 32'hDEAD, 32'h20), no_wb, 0, 0, 0,
          exm(1, 0, 0, 5, 32'hFFFF_FFEC, 32'h20));         // rs from EX/MEM
      add(r_id(FN_SLT, 6, 7, 8, 0, 32'hFFFF_FFFF, 1), no_wb, 0, 0, 0, exm(1, 0, 0, 8, 1, 1));
      add(i_id(OP_SLTI, 9, 10, 16'h8000, 32'hFFFF_0000, 32'h11), no_wb, 0, 0, 0,
          exm(1, 0, 0, 10, 1, 32'h11));
      add(i_id(OP_ANDI, 11, 12, 16'h8001, 32'hFFFF_FFFF, 0), no_wb, 0, 0, 0,
          exm(1, 0, 0, 12, 32'h8001, 0));
      add(i_id(OP_ADDIU, 11, 13, 16'hFFFF, 32'h10, 0), no_wb, 0, 0, 0, exm(1, 0, 0, 13, 32'hF, 0));
      add(i_id(OP_LUI, 0, 14, 16'h1234, 0, 0), no_wb, 0, 0, 0, exm(1, 0, 0, 14, 32'h1234_0000, 0));
      add(r_id(FN_SRA, 0, 15, 16, 4, 0, 32'h8000_0000), no_wb, 0, 0, 0,
          exm(1, 0, 0, 16, 32'hF800_0000, 32'h8000_0000));
      add(r_id(FN_SRAV, 17, 18, 19, 0, 32'h24, 32'hF000_0000), no_wb, 0, 0, 0,
          exm(1, 0, 0, 19, 32'hFF00_0000, 32'hF000_0000));
      add(r_id(FN_SLL, 0, 20, 21, 31, 0, 1), no_wb, 0, 0, 0, exm(1, 0, 0, 21, 32'h8000_0000, 1));
      add(r_id(FN_SRLV, 22, 23, 24, 0, 3, 32'h8000_0000), no_wb, 0, 0, 0,
          exm(1, 0, 0, 24, 32'h1000_0000, 32'h8000_0000));
      add(r_id(FN_ADDU, 25, 26, 27, 0, 5, 1), wbf(1, 25, 32'h100), 0, 0, 0,
          exm(1, 0, 0, 27, 32'h101, 1));                   // WB only
      add(r_id(FN_ADDU, 27, 0, 28, 0, 9, 2), wbf(1, 27, 32'h999), 0, 0, 0,
          exm(1, 0, 0, 28, 32'h103, 2));                   // EX/MEM beats WB
      add(r_id(FN_ADDU, 0, 0, 29, 0, 4, 6), wbf(1, 0, 32'h777), 0, 0, 0,
          exm(1, 0, 0, 29, 32'hA, 6));
      add(i_id(OP_LW, 29, 1, 16'h0010, 32'hBAD, 32'h33), no_wb, 0, 0, 0,
          exm(1, 1, 0, 1, 32'h1A, 32'h33));
      add(i_id(OP_SW, 2, 3, 16'hFFFC, 32'h100, 0), wbf(1, 3, 32'hCAFE), 0, 0, 0,
          exm(0, 0, 1, 0, 32'hFC, 32'hCAFE));
      add(i_id(OP_JAL, 4, 0, 0, 32'h400, 0), no_wb, 0, 0, 0, exm(1, 0, 0, 31, 32'h400, 0));
      add(r_id(FN_JALR, 5, 0, 30, 0, 32'h800, 0), no_wb, 0, 0, 0, exm(1, 0, 0, 31, 32'h800, 0));
      add(r_id(FN_ADDU, 1, 2, 3, 0, 1, 1), no_wb, 1, 1, 0, '0);
      add(r_id(FN_ADDU, 1, 2, 3, 0, 1, 1), no_wb, 1, 0, 0, '0);
      add(r_id(FN_ADDU, 1, 2, 3, 0, 1, 1), no_wb, 0, 1, 0, '0);
      add(r_id(FN_ADDU, 31, 0, 3, 0, 1, 2), no_wb, 0, 0, 0, exm(1, 0, 0, 3, 3, 2));
      // Random operands on register 0 so nothing forwards
      for (int k = 0; k < 22; k++)
      begin
         a = lcg_next();
         b = lcg_next();
         r = lcg_next();
         if (k < 15)
            add(r_id(fns[k], 0, 0, 9, r[4:0], a, b), no_wb, 0, 0, 1,
                exm(1, 0, 0, 9, ref_result(OP_RTYPE, fns[k], r[4:0], a, b, 16'h0), b));
         else
            add(i_id(ops[k-15], 0, 0, r[15:0], a, b), no_wb, 0, 0, 1,
                exm(1, 0, 0, 0, ref_result(ops[k-15], 6'h0, 5'h0, a, b, r[15:0]), b));
      end
   endtask

   // Limit follows the table length
   always @(posedge clk)
   begin
      cycles = cycles + 1;
      if (cycles >= 16 + 4 * table_q.size() + 20)
      begin
         $display("The run timed out after %0d cycles", cycles);
         $display("Result: FAILED");
         $finish;
      end
   end

   initial
   begin
      clk       = 1'b0;
      rst       = 1'b1;
      stall     = 1'b0;
      flush     = 1'b0;
      id_ex     = '0;
      wb_fwd    = '0;
      check     = 1'b0;
      index     = '0;
      cur_lcg   = 1'b0;
      cur_exp   = '0;
      cycles    = 0;
      lcg_state = 32'd73639;
      build_table();
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      foreach (table_q[i])
      begin
         id_ex   = table_q[i].id;
         wb_fwd  = table_q[i].wb;
         stall   = table_q[i].stall;
         flush   = table_q[i].flush;
         cur_lcg = table_q[i].is_lcg;
         cur_exp = table_q[i].exp;
         index   = i;
         check   = 1'b1;
         @(negedge clk);
      end
      check  = 1'b0;
      id_ex  = '0;
      wb_fwd = '0;
      stall  = 1'b0;
      flush  = 1'b0;
      while (checked < table_q.size())
         @(posedge clk);
      @(negedge clk);
      $display("Tests run %0d, passed %0d, failed %0d", checked, checked - failed, failed);
      if (failed == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== flist.f ====
design/mips_pkg.sv
design/ex_control.sv
design/operand_select.sv
design/alu.sv
design/ex_mem_reg.sv
design/execute_stage.sv
sim/ex_checker.sv
sim/tb_execute_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   -f flist.f --top-module tb_execute_stage -o sim_exec
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/sim_exec 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "Result: PASSED"; then
   exit 0
fi
exit 1
